// File: hw/rename_defines.svh
/* sizing macros for the rename stage
   include from every file that sizes ports, tables or the free fifo */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// ========================================
// pipeline widths
// ========================================

// rename slots per dispatch bundle
`define RN_DISPATCH_WIDTH 2

// commit slots retired per cycle
`define RN_COMMIT_WIDTH 2

// ========================================
// register counts
// ========================================

`define RN_ARCH_REGS 32
`define RN_PHYS_REGS 64

// free fifo depth, one entry per non-architectural register
`define RN_FREE_DEPTH (`RN_PHYS_REGS - `RN_ARCH_REGS)

`endif

// File: hw/rename_pkg.sv
/* register index types and the rename / commit slot structs
   shared by the rename tables and the top level */
`include "rename_defines.svh"

package rename_pkg;

    // ========================================
    // register indices
    // ========================================

    // architectural register number
    typedef logic [$clog2(`RN_ARCH_REGS)-1:0] areg_t;

    // physical register number
    typedef logic [$clog2(`RN_PHYS_REGS)-1:0] preg_t;

    // free count, 0 up to the full fifo depth
    typedef logic [$clog2(`RN_FREE_DEPTH+1)-1:0] fcount_t;

    // ========================================
    // slot structs
    // ========================================

    // one instruction entering rename
    typedef struct packed {
        logic  has_dest;
        areg_t dest;
        areg_t src1;
        areg_t src2;
    } rename_req_t;

    // renamed operands, old_pdest goes to the rob
    typedef struct packed {
        preg_t psrc1;
        preg_t psrc2;
        preg_t pdest;
        preg_t old_pdest;
    } rename_rsp_t;

    // one retiring instruction
    typedef struct packed {
        logic  valid;
        areg_t dest;
        preg_t pdest;
    } commit_t;

    // slot 0 is the oldest in every bundle
    typedef rename_req_t [`RN_DISPATCH_WIDTH-1:0] rename_bundle_t;
    typedef rename_rsp_t [`RN_DISPATCH_WIDTH-1:0] rename_result_t;
    typedef commit_t     [`RN_COMMIT_WIDTH-1:0]   commit_bundle_t;

endpackage

// File: hw/free_list.sv
/* circular fifo of free physical registers
   allocates per bundle, takes commit releases at the tail, rebuilds on flush */
`timescale 1ns/10ps
`include "rename_defines.svh"

module free_list (
    input  logic                                        clock,
    input  logic                                        reset,
    // allocation, one bit per slot that wants a register
    input  logic [`RN_DISPATCH_WIDTH-1:0]               alloc_mask_i,
    output logic                                        alloc_ok_o,
    output rename_pkg::preg_t [`RN_DISPATCH_WIDTH-1:0]  alloc_pregs_o,
    // release from the commit path
    input  logic [`RN_COMMIT_WIDTH-1:0]                 release_valid_i,
    input  rename_pkg::preg_t [`RN_COMMIT_WIDTH-1:0]    release_pregs_i,
    // flush rebuild source
    input  logic                                        flush_i,
    input  logic [`RN_PHYS_REGS-1:0]                    held_mask_i,
    output rename_pkg::fcount_t                         free_count_o
);
    import rename_pkg::*;

    typedef logic [$clog2(`RN_FREE_DEPTH)-1:0] fptr_t;

    // ring storage and pointers
    preg_t   fifo [`RN_FREE_DEPTH];
    fptr_t   head;
    fptr_t   tail;
    fcount_t count;

    // per-cycle bookkeeping
    int unsigned n_alloc;
    int unsigned n_take;
    int unsigned n_release;
    fptr_t       rel_addr [`RN_COMMIT_WIDTH];
    fcount_t     next_count;

    // flush image
    preg_t       rebuild_fifo [`RN_FREE_DEPTH];
    int unsigned rebuild_n;

    // wrap a pointer plus offset into the ring
    function automatic fptr_t ptr_add(fptr_t base, int unsigned offs);
        return fptr_t'((32'(base) + offs) % `RN_FREE_DEPTH);
    endfunction

    // ========================================
    // allocation
    // ========================================

    // slot i reads head plus the number of requesting slots before it
    always_comb begin
        int unsigned offs;
        offs = 0;
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            alloc_pregs_o[i] = fifo[ptr_add(head, offs)];
            if (alloc_mask_i[i]) begin
                offs = offs + 1;
            end
        end
        n_alloc = offs;
    end

    // checked against the registered count only
    assign alloc_ok_o = (n_alloc <= 32'(count));
    // mask already carries valid and no-flush, ok completes the grant
    assign n_take = alloc_ok_o ? n_alloc : 0;

    // ========================================
    // release
    // ========================================

    // releases pack at the tail in slot order
    always_comb begin
        int unsigned offs;
        offs = 0;
        for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
            rel_addr[j] = ptr_add(tail, offs);
            if (release_valid_i[j]) begin
                offs = offs + 1;
            end
        end
        n_release = offs;
    end

    // count from the traffic, a full ring has head == tail
    assign next_count = fcount_t'(32'(count) + n_release - n_take);

    // unmapped registers in ascending order from entry 0
    always_comb begin
        int unsigned n;
        n = 0;
        for (int e = 0; e < `RN_FREE_DEPTH; e++) begin
            rebuild_fifo[e] = '0;
        end
        for (int p = 0; p < `RN_PHYS_REGS; p++) begin
            if (!held_mask_i[p] && n < `RN_FREE_DEPTH) begin
                rebuild_fifo[n] = preg_t'(p);
                n = n + 1;
            end
        end
        rebuild_n = n;
    end

    // ========================================
    // state update
    // ========================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= fcount_t'(`RN_FREE_DEPTH);
            // registers above the identity map start free
            for (int e = 0; e < `RN_FREE_DEPTH; e++) begin
                fifo[e] <= preg_t'(`RN_ARCH_REGS + e);
            end
        end else if (flush_i) begin
            head  <= '0;
            tail  <= ptr_add('0, rebuild_n);
            count <= fcount_t'(rebuild_n);
            for (int e = 0; e < `RN_FREE_DEPTH; e++) begin
                fifo[e] <= rebuild_fifo[e];
            end
        end else begin
            head  <= ptr_add(head, n_take);
            tail  <= ptr_add(tail, n_release);
            count <= next_count;
            for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
                if (release_valid_i[j]) begin
                    fifo[rel_addr[j]] <= release_pregs_i[j];
                end
            end
        end
    end

    assign free_count_o = count;

endmodule

// File: hw/map_table.sv
/* speculative architectural-to-physical map
   renames a bundle with in-bundle bypass and reloads from the committed map on flush */
`timescale 1ns/10ps
`include "rename_defines.svh"

module map_table (
    input  logic                                        clock,
    input  logic                                        reset,
    // bundle being renamed this cycle
    input  rename_pkg::rename_bundle_t                  bundle_i,
    input  logic                                        take_i,
    input  rename_pkg::preg_t [`RN_DISPATCH_WIDTH-1:0]  alloc_pregs_i,
    output rename_pkg::rename_result_t                  result_o,
    // recovery
    input  logic                                        flush_i,
    input  rename_pkg::preg_t [`RN_ARCH_REGS-1:0]       arch_table_i
);
    import rename_pkg::*;

    // one physical register per architectural register
    preg_t spec_map [`RN_ARCH_REGS];

    // ========================================
    // lookup with in-bundle bypass
    // ========================================

    always_comb begin
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            // table values first
            result_o[i].psrc1     = spec_map[bundle_i[i].src1];
            result_o[i].psrc2     = spec_map[bundle_i[i].src2];
            result_o[i].old_pdest = spec_map[bundle_i[i].dest];
            // new register, meaningful only with has_dest
            result_o[i].pdest     = alloc_pregs_i[i];

            // older slots override in age order, youngest writer last
            for (int k = 0; k < i; k++) begin
                if (bundle_i[k].has_dest) begin
                    if (bundle_i[k].dest == bundle_i[i].src1) begin
                        result_o[i].psrc1 = alloc_pregs_i[k];
                    end
                    if (bundle_i[k].dest == bundle_i[i].src2) begin
                        result_o[i].psrc2 = alloc_pregs_i[k];
                    end
                    // same destination, the rob frees the older new mapping
                    if (bundle_i[k].dest == bundle_i[i].dest) begin
                        result_o[i].old_pdest = alloc_pregs_i[k];
                    end
                end
            end
        end
    end

    // ========================================
    // table update
    // ========================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // identity map out of reset
            for (int a = 0; a < `RN_ARCH_REGS; a++) begin
                spec_map[a] <= preg_t'(a);
            end
        end else if (flush_i) begin
            // back to the committed state
            for (int a = 0; a < `RN_ARCH_REGS; a++) begin
                spec_map[a] <= arch_table_i[a];
            end
        end else if (take_i) begin
            // ascending slot order, later slot wins on a shared dest
            for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
                if (bundle_i[i].has_dest) begin
                    spec_map[bundle_i[i].dest] <= alloc_pregs_i[i];
                end
            end
        end
    end

endmodule

// File: hw/arch_map.sv
/* committed architectural map
   retires commit slots, returns the replaced registers and reports which are held */
`timescale 1ns/10ps
`include "rename_defines.svh"

module arch_map (
    input  logic                                      clock,
    input  logic                                      reset,
    input  rename_pkg::commit_bundle_t                commit_i,
    // replaced mappings, back to the free list
    output logic [`RN_COMMIT_WIDTH-1:0]               release_valid_o,
    output rename_pkg::preg_t [`RN_COMMIT_WIDTH-1:0]  release_pregs_o,
    // committed state for flush recovery
    output rename_pkg::preg_t [`RN_ARCH_REGS-1:0]     arch_table_o,
    output logic [`RN_PHYS_REGS-1:0]                  held_mask_o
);
    import rename_pkg::*;

    preg_t [`RN_ARCH_REGS-1:0] arch_q;

    // previous mapping of each commit, older slot in the same cycle first
    always_comb begin
        for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
            release_valid_o[j] = commit_i[j].valid;
            release_pregs_o[j] = arch_q[commit_i[j].dest];
            for (int k = 0; k < j; k++) begin
                if (commit_i[k].valid && commit_i[k].dest == commit_i[j].dest) begin
                    release_pregs_o[j] = commit_i[k].pdest;
                end
            end
        end
    end

    // one bit per physical register that some arch register points at
    always_comb begin
        held_mask_o = '0;
        for (int a = 0; a < `RN_ARCH_REGS; a++) begin
            held_mask_o[arch_q[a]] = 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int a = 0; a < `RN_ARCH_REGS; a++) begin
                arch_q[a] <= preg_t'(a);
            end
        end else begin
            // younger slot lands last
            for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
                if (commit_i[j].valid) begin
                    arch_q[commit_i[j].dest] <= commit_i[j].pdest;
                end
            end
        end
    end

    assign arch_table_o = arch_q;

endmodule

// File: hw/rename_unit.sv
/* two-wide register rename stage
   forms the grant and ties the free list, speculative map and committed map together */
`timescale 1ns/10ps
`include "rename_defines.svh"

module rename_unit (
    input  logic                        clock,
    input  logic                        reset,
    // rename request / grant
    input  logic                        rename_valid_i,
    input  rename_pkg::rename_bundle_t  rename_bundle_i,
    output logic                        rename_grant_o,
    output rename_pkg::rename_result_t  rename_result_o,
    // retire and recovery
    input  rename_pkg::commit_bundle_t  commit_i,
    input  logic                        flush_i,
    output rename_pkg::fcount_t         free_count_o
);
    import rename_pkg::*;

    // ========================================
    // grant
    // ========================================

    logic                                rename_req;
    logic [`RN_DISPATCH_WIDTH-1:0]       alloc_mask;
    logic                                alloc_ok;
    preg_t [`RN_DISPATCH_WIDTH-1:0]      alloc_pregs;

    // commit to free list
    logic [`RN_COMMIT_WIDTH-1:0]         release_valid;
    preg_t [`RN_COMMIT_WIDTH-1:0]        release_pregs;

    // committed state for flush
    preg_t [`RN_ARCH_REGS-1:0]           arch_table;
    logic [`RN_PHYS_REGS-1:0]            held_mask;

    // flush drops the bundle of its cycle
    assign rename_req = rename_valid_i && !flush_i;

    // all-or-nothing, the whole has_dest mask is checked at once
    always_comb begin
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            alloc_mask[i] = rename_bundle_i[i].has_dest && rename_req;
        end
    end

    assign rename_grant_o = rename_req && alloc_ok;

    // ========================================
    // tables
    // ========================================

    free_list u_free_list (
        .clock           (clock),
        .reset           (reset),
        .alloc_mask_i    (alloc_mask),
        .alloc_ok_o      (alloc_ok),
        .alloc_pregs_o   (alloc_pregs),
        .release_valid_i (release_valid),
        .release_pregs_i (release_pregs),
        .flush_i         (flush_i),
        .held_mask_i     (held_mask),
        .free_count_o    (free_count_o)
    );

    // map only moves on a granted bundle
    map_table u_map_table (
        .clock         (clock),
        .reset         (reset),
        .bundle_i      (rename_bundle_i),
        .take_i        (rename_grant_o),
        .alloc_pregs_i (alloc_pregs),
        .result_o      (rename_result_o),
        .flush_i       (flush_i),
        .arch_table_i  (arch_table)
    );

    arch_map u_arch_map (
        .clock           (clock),
        .reset           (reset),
        .commit_i        (commit_i),
        .release_valid_o (release_valid),
        .release_pregs_o (release_pregs),
        .arch_table_o    (arch_table),
        .held_mask_o     (held_mask)
    );

endmodule

// File: bench/rename_unit_sva.sv
/* protocol and free-list assertions for the rename stage
   bound into every rename_unit instance by the bind below */
`timescale 1ns/10ps
`include "rename_defines.svh"

module rename_unit_sva (
    input logic                        clock,
    input logic                        reset,
    input logic                        flush_i,
    input rename_pkg::commit_bundle_t  commit_i,
    input rename_pkg::rename_bundle_t  rename_bundle_i,
    input logic                        rename_grant_o,
    input rename_pkg::rename_result_t  rename_result_o,
    input rename_pkg::fcount_t         free_count_o
);
    import rename_pkg::*;

    logic any_commit;

    // any commit slot retiring this cycle
    always_comb begin
        any_commit = 1'b0;
        for (int j = 0; j < `RN_COMMIT_WIDTH; j++) begin
            any_commit = any_commit | commit_i[j].valid;
        end
    end

    // ========================================
    // protocol
    // ========================================

    // recovery and retire never share a cycle
    flush_no_commit: assert property (@(posedge clock) disable iff (reset)
        !(flush_i && any_commit))
        else $error("flush raised in a cycle with a commit");

    // flush drops its bundle and leaves the free list full at the next edge
    flush_refill: assert property (@(posedge clock) disable iff (reset)
        flush_i |=> (free_count_o == fcount_t'(`RN_FREE_DEPTH)))
        else $error("free count not full after a flush");

    // ========================================
    // free list
    // ========================================

    count_in_range: assert property (@(posedge clock) disable iff (reset)
        free_count_o <= fcount_t'(`RN_FREE_DEPTH))
        else $error("free count above the fifo depth");

    // two new registers in one bundle must differ
    distinct_alloc: assert property (@(posedge clock) disable iff (reset)
        (rename_grant_o && rename_bundle_i[0].has_dest && rename_bundle_i[1].has_dest)
        |-> (rename_result_o[0].pdest != rename_result_o[1].pdest))
        else $error("same physical register given to both slots");

endmodule

bind rename_unit rename_unit_sva u_rename_sva (
    .clock           (clock),
    .reset           (reset),
    .flush_i         (flush_i),
    .commit_i        (commit_i),
    .rename_bundle_i (rename_bundle_i),
    .rename_grant_o  (rename_grant_o),
    .rename_result_o (rename_result_o),
    .free_count_o    (free_count_o)
);

// File: bench/rename_unit_tb.sv
/* random testbench for the two-wide rename stage
   drives bundles, commits and flushes and checks them against a reference model */
`timescale 1ns/10ps
`include "rename_defines.svh"

module rename_unit_tb;
    import rename_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RUN_CYCLES   = 2500;
    localparam int SETTLE_NS    = 10;
    localparam int SEED         = 21999;
    // run length plus margin and the reset time
    localparam int LIMIT_NS     = (RUN_CYCLES + 500 + RESET_CYCLES) * CLK_PERIOD;

    logic           clock;
    logic           reset;
    logic           rename_valid_i;
    rename_bundle_t rename_bundle_i;
    logic           rename_grant_o;
    rename_result_t rename_result_o;
    commit_bundle_t commit_i;
    logic           flush_i;
    fcount_t        free_count_o;

    // ========================================
    // reference model state
    // ========================================
    preg_t   spec_m [`RN_ARCH_REGS];
    preg_t   arch_m [`RN_ARCH_REGS];
    preg_t   free_q [$];
    // renamed but not yet retired in age order
    commit_t pend_q [$];
    logic    saw_stall;
    logic    saw_empty_grant;

    rename_unit dut_i (
        .clock           (clock),
        .reset           (reset),
        .rename_valid_i  (rename_valid_i),
        .rename_bundle_i (rename_bundle_i),
        .rename_grant_o  (rename_grant_o),
        .rename_result_o (rename_result_o),
        .commit_i        (commit_i),
        .flush_i         (flush_i),
        .free_count_o    (free_count_o)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_result(input string name, input rename_rsp_t got,
                                input rename_rsp_t exp, input logic use_pdest);
        if (got.psrc1 !== exp.psrc1 || got.psrc2 !== exp.psrc2 ||
            got.old_pdest !== exp.old_pdest || (use_pdest && got.pdest !== exp.pdest)) begin
            $display("mismatch at %0t: %s got psrc1=%0d psrc2=%0d pdest=%0d old=%0d",
                     $time, name, got.psrc1, got.psrc2, got.pdest, got.old_pdest);
            $display("    expected psrc1=%0d psrc2=%0d pdest=%0d old=%0d",
                     exp.psrc1, exp.psrc2, exp.pdest, exp.old_pdest);
            abort_run();
        end
    endtask

    task automatic check_grant(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: rename_grant_o got %b expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input fcount_t got, input fcount_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: free_count_o got %0d expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    // flush image with every unmapped register free in ascending order
    function automatic void restore_from_arch();
        logic [`RN_PHYS_REGS-1:0] held;
        held = '0;
        for (int a = 0; a < `RN_ARCH_REGS; a++) begin
            spec_m[a] = arch_m[a];
            held[arch_m[a]] = 1'b1;
        end
        free_q.delete();
        for (int p = 0; p < `RN_PHYS_REGS; p++) begin
            if (!held[p]) begin
                free_q.push_back(preg_t'(p));
            end
        end
        pend_q.delete();
    endfunction

    function automatic rename_bundle_t random_bundle();
        rename_bundle_t b;
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            b[i].has_dest = ($urandom % 4) != 0;
            b[i].dest     = areg_t'($urandom);
            b[i].src1     = areg_t'($urandom);
            b[i].src2     = areg_t'($urandom);
        end
        // steer slot 1 onto slot 0's destination now and then
        if ($urandom % 4 == 0) begin
            b[1].src1 = b[0].dest;
        end
        if ($urandom % 6 == 0) begin
            b[1].src2 = b[0].dest;
        end
        if ($urandom % 8 == 0) begin
            b[1].dest = b[0].dest;
        end
        return b;
    endfunction

    // ========================================
    // one cycle driven on the falling edge and checked before the rising one
    // ========================================
    task automatic step(input logic valid, input rename_bundle_t bnd,
                        input int n_commit, input logic flush);
        commit_bundle_t cb;
        rename_rsp_t    exp_rsp;
        preg_t          new_p [`RN_DISPATCH_WIDTH];
        int             need;
        logic           exp_grant;
        commit_t        c;
        preg_t          old_p;

        cb = '0;
        for (int j = 0; j < n_commit; j++) begin
            cb[j] = pend_q[j];
        end
        @(negedge clock);
        rename_valid_i  = valid;
        rename_bundle_i = bnd;
        commit_i        = cb;
        flush_i         = flush;
        #(SETTLE_NS);

        // free registers taken in slot order from the fifo head
        need = 0;
        for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
            new_p[i] = '0;
            if (bnd[i].has_dest) begin
                if (need < free_q.size()) begin
                    new_p[i] = free_q[need];
                end
                need++;
            end
        end
        exp_grant = valid && !flush && (need <= free_q.size());
        if (valid && !flush && !exp_grant && free_q.size() == 0) begin
            saw_stall = 1'b1;
        end
        check_count(free_count_o, fcount_t'(free_q.size()));
        check_grant(rename_grant_o, exp_grant);

        if (exp_grant) begin
            if (free_q.size() == 0) begin
                saw_empty_grant = 1'b1;
            end
            for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
                exp_rsp.psrc1     = spec_m[bnd[i].src1];
                exp_rsp.psrc2     = spec_m[bnd[i].src2];
                exp_rsp.old_pdest = spec_m[bnd[i].dest];
                exp_rsp.pdest     = new_p[i];
                // older slot's new mapping wins inside the bundle
                for (int k = 0; k < i; k++) begin
                    if (bnd[k].has_dest && bnd[k].dest == bnd[i].src1) begin
                        exp_rsp.psrc1 = new_p[k];
                    end
                    if (bnd[k].has_dest && bnd[k].dest == bnd[i].src2) begin
                        exp_rsp.psrc2 = new_p[k];
                    end
                    if (bnd[k].has_dest && bnd[k].dest == bnd[i].dest) begin
                        exp_rsp.old_pdest = new_p[k];
                    end
                end
                check_result($sformatf("rename_result_o[%0d]", i), rename_result_o[i],
                             exp_rsp, bnd[i].has_dest);
            end
        end

        // model moves as the tables do at the next edge
        if (flush) begin
            restore_from_arch();
        end else begin
            if (exp_grant) begin
                for (int i = 0; i < `RN_DISPATCH_WIDTH; i++) begin
                    if (bnd[i].has_dest) begin
                        void'(free_q.pop_front());
                        spec_m[bnd[i].dest] = new_p[i];
                        c.valid = 1'b1;
                        c.dest  = bnd[i].dest;
                        c.pdest = new_p[i];
                        pend_q.push_back(c);
                    end
                end
            end
            // retire oldest first and send the replaced mapping to the tail
            for (int j = 0; j < n_commit; j++) begin
                c = pend_q.pop_front();
                old_p = arch_m[c.dest];
                arch_m[c.dest] = c.pdest;
                free_q.push_back(old_p);
            end
        end
    endtask

    // ========================================
    // watchdog
    // ========================================
    initial begin
        #(LIMIT_NS);
        $display("timeout: run did not finish within %0d ns", LIMIT_NS);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    // ========================================
    // main sequence
    // ========================================
    initial begin
        rename_bundle_t b;
        int             n_commit;
        logic           flush;
        logic           valid;

        void'($urandom(SEED));
        clock           = 1'b0;
        reset           = 1'b1;
        rename_valid_i  = 1'b0;
        rename_bundle_i = '0;
        commit_i        = '0;
        flush_i         = 1'b0;
        saw_stall       = 1'b0;
        saw_empty_grant = 1'b0;

        // identity maps out of reset with registers 32 and up free in order
        for (int a = 0; a < `RN_ARCH_REGS; a++) begin
            spec_m[a] = preg_t'(a);
            arch_m[a] = preg_t'(a);
        end
        for (int e = 0; e < `RN_FREE_DEPTH; e++) begin
            free_q.push_back(preg_t'(`RN_ARCH_REGS + e));
        end

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        #(SETTLE_NS);
        check_count(free_count_o, fcount_t'(`RN_FREE_DEPTH));

        // first bundle writes two registers and gets 32 and 33
        b = '0;
        b[0] = '{has_dest: 1'b1, dest: 5'd3, src1: 5'd1, src2: 5'd2};
        b[1] = '{has_dest: 1'b1, dest: 5'd5, src1: 5'd6, src2: 5'd7};
        step(1'b1, b, 0, 1'b0);

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            // alternate drain phases and commit bursts
            if ((cyc / 150) % 2 == 0) begin
                n_commit = ($urandom % 8 == 0) ? 1 : 0;
            end else begin
                n_commit = $urandom % (`RN_COMMIT_WIDTH + 1);
            end
            if (n_commit > pend_q.size()) begin
                n_commit = pend_q.size();
            end
            flush = (n_commit == 0) && ($urandom % 64 == 0);
            valid = ($urandom % 8) != 0;
            step(valid, random_bundle(), n_commit, flush);
        end

        if (!saw_stall || !saw_empty_grant) begin
            $display("free list was never drained to a stall with a no-dest grant");
            $display("** FAIL **");
            $fatal(1, "drain case not reached");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: rename_unit.f
+incdir+hw
hw/rename_pkg.sv
hw/free_list.sv
hw/map_table.sv
hw/arch_map.sv
hw/rename_unit.sv
bench/rename_unit_sva.sv
bench/rename_unit_tb.sv

// File: Makefile
# Verilator build for the rename stage testbench
# the exit status of "make run" is the pass or fail of the simulation

TOP = rename_unit_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f rename_unit.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
